// ==== common/dai_config.svh ====
`ifndef DAI_CONFIG_SVH
`define DAI_CONFIG_SVH

// ring geometry
// pointer width sets the depth, indices wrap naturally
`define DAI_PTR_W       6
`define DAI_RING_DEPTH  64

// audio word width as delivered by the deserializer
// sits left aligned in a 32 bit I2S slot
`define DAI_SAMPLE_W    24

// R bus regions, taken from addr[15:12]
// unread register at {region, ch, 8'h00}
`define DAI_REG_REGION  4'hd
// sample window at {region, ch, offset}
`define DAI_WIN_REGION  4'hf

// left and right
// channel field values at or above this read as zero
`define DAI_NUM_CH      2

`endif

// ==== common/dai_pkg.sv ====
`include "dai_config.svh"

package dai_pkg;

    // one audio sample
    typedef logic [`DAI_SAMPLE_W-1:0] sample_t;

    // ring index and unread count share the pointer width
    typedef logic [`DAI_PTR_W-1:0] ring_ptr_t;
    typedef logic [`DAI_PTR_W-1:0] unread_t;

    // R bus words
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // channel field, addr[11:8]
    typedef logic [3:0] chan_t;

    // deserializer output
    // ch 0 is left (lrclk low), ack is a single cycle strobe
    typedef struct packed {
        sample_t data;
        logic    ch;
        logic    ack;
    } rx_sample_s;

    // bus request as seen by the core side
    // we is a level, sampled every cycle
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t data;
        logic      we;
    } rbus_req_s;

    // what the readback register loads
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_UNREAD,
        SEL_WINDOW
    } read_sel_e;

    // deserializer word FSM
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } deser_state_e;

endpackage

// ==== dai_rx/i2s_rx_deser.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module i2s_rx_deser (
    input  logic                clk,
    input  logic                rst,
    input  logic                bclk_i,
    input  logic                lrclk_i,
    input  logic                sdata_i,
    output dai_pkg::rx_sample_s sample_o
);
    import dai_pkg::*;

    // counts captured bits 0 .. sample width - 1
    localparam int CNT_W = $clog2(`DAI_SAMPLE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`DAI_SAMPLE_W - 1);

    deser_state_e     state;
    logic             bclk_q;
    logic             lr_prev;
    logic             bclk_rise;
    logic             word_start;
    logic             begin_word;
    logic [CNT_W-1:0] bit_cnt;
    sample_t          shreg;
    logic             ch_q;

    // pin history
    // lrclk is compared at bit clock rises only, the level during reset is the start point
    always_ff @(posedge clk) begin
        bclk_q <= bclk_i;
        if (rst || bclk_rise) begin
            lr_prev <= lrclk_i;
        end
    end

    assign bclk_rise = bclk_i && !bclk_q;

    // lrclk moved since the last rise
    // this rise is the one bit delay slot, MSB follows on the next rise
    assign word_start = bclk_rise && (lrclk_i != lr_prev);

    // no restart while ack is out, keeps data and ch stable for the ring
    assign begin_word = word_start && (state != DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (begin_word) begin
                        state   <= SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SHIFT: begin
                    if (begin_word) begin
                        // short word, drop it and restart
                        bit_cnt <= '0;
                    end else if (bclk_rise) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DONE: begin
                    // single ack cycle
                    // trailing slot bits are ignored in IDLE
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload, MSB first
    always_ff @(posedge clk) begin
        if (begin_word) begin
            // lrclk high means right
            ch_q <= lrclk_i;
        end
        if (state == SHIFT && bclk_rise && !begin_word) begin
            shreg <= {shreg[`DAI_SAMPLE_W-2:0], sdata_i};
        end
    end

    // ack is high the cycle after the LSB capture
    assign sample_o = '{data: shreg, ch: ch_q, ack: (state == DONE)};

    // a sample is delivered once
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        sample_o.ack |=> !sample_o.ack
    ) else $error("i2s_rx_deser: ack held for two cycles");

endmodule

// ==== dai_rx/dai_rx_ring.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module dai_rx_ring (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en_i,
    input  dai_pkg::sample_t   wr_data_i,
    input  logic               shift_i,
    input  dai_pkg::ring_ptr_t offset_i,
    output dai_pkg::sample_t   win_data_o,
    output dai_pkg::unread_t   unread_o
);
    import dai_pkg::*;

    sample_t   mem [`DAI_RING_DEPTH];
    ring_ptr_t wr_ptr;
    ring_ptr_t rd_ptr;
    ring_ptr_t win_idx;
    unread_t   unread;

    // write side
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // read side
    // shift retires the oldest sample
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            unread <= '0;
        end else begin
            case ({shift_i, wr_en_i})
                2'b10: begin
                    unread <= unread - 1'b1;
                    rd_ptr <= rd_ptr + 1'b1;
                end
                2'b01: begin
                    unread <= unread + 1'b1;
                end
                2'b11: begin
                    // one in and one out so the count holds
                    rd_ptr <= rd_ptr + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // window wraps modulo depth through the pointer width
    assign win_idx    = rd_ptr + offset_i;
    assign win_data_o = mem[win_idx];
    assign unread_o   = unread;

    // count full at 63
    // one more write would alias the oldest entry
    no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (wr_en_i && !shift_i) |-> (unread != '1)
    ) else $error("dai_rx_ring: write with ring full");

    no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (shift_i && !wr_en_i) |-> (unread != '0)
    ) else $error("dai_rx_ring: shift with nothing unread");

endmodule

// ==== logic/rbus_decode.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module rbus_decode (
    input  dai_pkg::rbus_req_s  req_i,
    output logic [1:0]          shift_o,
    output dai_pkg::read_sel_e  sel_o,
    output logic                ch_o,
    output dai_pkg::ring_ptr_t  offset_o
);
    import dai_pkg::*;

    logic [3:0] region;
    chan_t      chan;
    logic [7:0] low_byte;
    logic       ch_valid;
    logic       unread_hit;
    logic       win_hit;

    // address layout {region[15:12], ch[11:8], low[7:0]}
    // bits 31:16 are not decoded
    assign region   = req_i.addr[15:12];
    assign chan     = req_i.addr[11:8];
    assign low_byte = req_i.addr[7:0];

    // only left and right exist
    assign ch_valid = (chan < chan_t'(`DAI_NUM_CH));

    assign unread_hit = ch_valid && (region == `DAI_REG_REGION) && (low_byte == 8'h00);
    // offset is addr[5:0], bits 7:6 ignored
    assign win_hit    = ch_valid && (region == `DAI_WIN_REGION);

    always_comb begin
        if (unread_hit) begin
            sel_o = SEL_UNREAD;
        end else if (win_hit) begin
            sel_o = SEL_WINDOW;
        end else begin
            sel_o = SEL_NONE;
        end
    end

    // write to the unread address retires one sample
    // written data is don't care
    always_comb begin
        shift_o = '0;
        for (int c = 0; c < `DAI_NUM_CH; c++) begin
            shift_o[c] = req_i.we && unread_hit && (chan == chan_t'(c));
        end
    end

    // low bit is enough once the channel is known valid
    assign ch_o     = chan[0];
    assign offset_o = req_i.addr[`DAI_PTR_W-1:0];

endmodule

// ==== logic/rbus_readback.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module rbus_readback (
    input  logic                    clk,
    input  logic                    rst,
    input  dai_pkg::read_sel_e      sel_i,
    input  logic                    ch_i,
    input  dai_pkg::sample_t [1:0]  win_data_i,
    input  dai_pkg::unread_t [1:0]  unread_i,
    output dai_pkg::bus_data_t      data_o
);
    import dai_pkg::*;

    bus_data_t rd_value;

    // pick channel and kind, zero extend to the bus width
    // ring values are sampled before this edge's update
    always_comb begin
        case (sel_i)
            SEL_UNREAD: rd_value = {{(32 - `DAI_PTR_W){1'b0}}, unread_i[ch_i]};
            SEL_WINDOW: rd_value = {{(32 - `DAI_SAMPLE_W){1'b0}}, win_data_i[ch_i]};
            default:    rd_value = '0;
        endcase
    end

    // registered bus data
    always_ff @(posedge clk) begin
        if (rst) begin
            data_o <= '0;
        end else begin
            data_o <= rd_value;
        end
    end

endmodule

// ==== dai_rx/dai_rx_top.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module dai_rx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                bclk_i,
    input  logic                lrclk_i,
    input  logic                sdata_i,
    input  dai_pkg::rbus_req_s  req_i,
    output dai_pkg::bus_data_t  data_o
);
    import dai_pkg::*;

    rx_sample_s                     rx_sample;
    logic [`DAI_NUM_CH-1:0]         ring_wr;
    logic [1:0]                     shift;
    read_sel_e                      sel;
    logic                           ch;
    ring_ptr_t                      offset;
    sample_t [`DAI_NUM_CH-1:0]      win_data;
    unread_t [`DAI_NUM_CH-1:0]      unread;

    // pins in, tagged samples out
    i2s_rx_deser u_deser (
        .clk      (clk),
        .rst      (rst),
        .bclk_i   (bclk_i),
        .lrclk_i  (lrclk_i),
        .sdata_i  (sdata_i),
        .sample_o (rx_sample)
    );

    // one ring per channel
    // the channel bit of the sample picks the ring
    for (genvar g = 0; g < `DAI_NUM_CH; g++) begin : g_ring
        assign ring_wr[g] = rx_sample.ack && (rx_sample.ch == 1'(g));

        dai_rx_ring u_ring (
            .clk        (clk),
            .rst        (rst),
            .wr_en_i    (ring_wr[g]),
            .wr_data_i  (rx_sample.data),
            .shift_i    (shift[g]),
            .offset_i   (offset),
            .win_data_o (win_data[g]),
            .unread_o   (unread[g])
        );
    end

    // address decode, all combinational
    rbus_decode u_decode (
        .req_i    (req_i),
        .shift_o  (shift),
        .sel_o    (sel),
        .ch_o     (ch),
        .offset_o (offset)
    );

    // one cycle read latency
    rbus_readback u_readback (
        .clk        (clk),
        .rst        (rst),
        .sel_i      (sel),
        .ch_i       (ch),
        .win_data_i (win_data),
        .unread_i   (unread),
        .data_o     (data_o)
    );

endmodule

// ==== bench/tb_checker.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module tb_checker (
    input  logic                clk,
    input  logic                rst,
    input  dai_pkg::rbus_req_s  req_i,
    input  dai_pkg::bus_data_t  data_i,
    input  logic                note_valid_i,
    input  logic                note_ch_i,
    input  dai_pkg::sample_t    note_data_i,
    output int                  err_cnt_o
);
    import dai_pkg::*;

    // cycles from the notice until the sample counts as unread
    localparam int LAND_MARGIN = 4;

    logic [23:0] model_mem [2][64];
    int          wr_cnt [2];
    int          rd_cnt [2];
    int          cyc;
    int          err_cnt;
    logic [31:0] exp_data;
    logic [23:0] pend_data [$];
    logic        pend_ch [$];
    int          pend_due [$];

    assign err_cnt_o = err_cnt;

    // address {region, ch, low}
    function automatic logic is_shift_addr(input logic [31:0] addr);
        return addr[15:12] == 4'hd && addr[11:8] < 4'd2 && addr[7:0] == 8'h00;
    endfunction

    // expected bus data for one request, from the model state before the edge
    function logic [31:0] expected_read(input logic [31:0] addr);
        logic [3:0] region;
        logic [3:0] ch;
        logic [7:0] low;
        int         idx;
        region = addr[15:12];
        ch     = addr[11:8];
        low    = addr[7:0];
        if (ch > 4'd1) begin
            return 32'h0;
        end
        if (region == 4'hd && low == 8'h00) begin
            return 32'(wr_cnt[ch[0]] - rd_cnt[ch[0]]);
        end
        if (region == 4'hf) begin
            // window wraps modulo the ring depth
            idx = (rd_cnt[ch[0]] + int'(addr[5:0])) % 64;
            return {8'h00, model_mem[ch[0]][idx]};
        end
        return 32'h0;
    endfunction

    initial begin
        err_cnt  = 0;
        cyc      = 0;
        exp_data = '0;
        wr_cnt   = '{0, 0};
        rd_cnt   = '{0, 0};
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 64; i++) begin
                model_mem[c][i] = '0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_data = '0;
        end else begin
            // data_o now holds the answer to last cycle's request
            if (data_i !== exp_data) begin
                err_cnt++;
                $display("FAILED at %0t ns: data_o expected %h actual %h",
                         $time, exp_data, data_i);
            end
            exp_data = expected_read(req_i.addr);
            if (req_i.we && is_shift_addr(req_i.addr)) begin
                if (wr_cnt[req_i.addr[8]] == rd_cnt[req_i.addr[8]]) begin
                    err_cnt++;
                    $display("at %0t ns the bench shifted a channel with nothing unread", $time);
                end
                rd_cnt[req_i.addr[8]]++;
            end
            if (note_valid_i) begin
                pend_data.push_back(note_data_i);
                pend_ch.push_back(note_ch_i);
                pend_due.push_back(cyc + LAND_MARGIN);
            end
            // samples become visible once the margin has passed
            while (pend_due.size() > 0 && pend_due[0] <= cyc) begin
                model_mem[pend_ch[0]][wr_cnt[pend_ch[0]] % 64] = pend_data[0];
                wr_cnt[pend_ch[0]]++;
                void'(pend_data.pop_front());
                void'(pend_ch.pop_front());
                void'(pend_due.pop_front());
            end
            cyc++;
        end
    end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
`include "dai_config.svh"

module tb_top;
    import dai_pkg::*;

    localparam int NUM_WORDS  = 142;
    localparam int BCLK_NS    = 32;
    localparam int TIMEOUT_NS = NUM_WORDS * BCLK_NS * 32 + 50000;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       bclk;
    logic       lrclk;
    logic       sdata;
    rbus_req_s  req;
    bus_data_t  data;
    logic       note_valid;
    logic       note_ch;
    sample_t    note_data;
    int         err_cnt;
    logic [31:0] rng = 32'h7f66_c821;

    always #2 clk = ~clk;

    dai_rx_top uut (
        .clk     (clk),
        .rst     (rst),
        .bclk_i  (bclk),
        .lrclk_i (lrclk),
        .sdata_i (sdata),
        .req_i   (req),
        .data_o  (data)
    );

    tb_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .data_i       (data),
        .note_valid_i (note_valid),
        .note_ch_i    (note_ch),
        .note_data_i  (note_data),
        .err_cnt_o    (err_cnt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] reg_addr(input int ch);
        return {16'h0, `DAI_REG_REGION, 4'(ch), 8'h00};
    endfunction

    function automatic logic [31:0] win_addr(input int ch, input int off);
        return {16'h0, `DAI_WIN_REGION, 4'(ch), 2'b00, 6'(off)};
    endfunction

    // one request held for a cycle, then idle for a cycle
    task automatic bus_op(input logic [31:0] addr, input logic we);
        req <= '{addr: addr, data: 32'hdead_beef, we: we};
        @(posedge clk);
        req <= '0;
        @(posedge clk);
    endtask

    // one bit slot, data changes with bclk low, bclk high for the second half
    task automatic bit_slot(input logic lr, input logic d);
        bclk  <= 1'b0;
        lrclk <= lr;
        sdata <= d;
        repeat (4) @(posedge clk);
        bclk <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    // 32 slot I2S word: delay slot, 24 bits MSB first, padding
    task automatic send_word(input logic ch, input logic shift_at_land);
        sample_t w;
        rng = xorshift32(rng);
        w   = rng[23:0];
        bit_slot(ch, 1'b0);
        for (int i = 23; i > 0; i--) begin
            bit_slot(ch, w[i]);
        end
        // LSB slot, the sample lands two clk after the rising bclk
        bclk  <= 1'b0;
        sdata <= w[0];
        repeat (4) @(posedge clk);
        bclk <= 1'b1;
        @(posedge clk);
        note_valid <= 1'b1;
        note_ch    <= ch;
        note_data  <= w;
        if (shift_at_land) begin
            req <= '{addr: reg_addr(int'(ch)), data: 32'h0, we: 1'b1};
        end
        @(posedge clk);
        note_valid <= 1'b0;
        req        <= '0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 7; i++) begin
            bit_slot(ch, 1'b0);
        end
    endtask

    task automatic read_counts();
        bus_op(reg_addr(0), 1'b0);
        bus_op(reg_addr(1), 1'b0);
    endtask

    initial begin
        bclk       = 1'b0;
        lrclk      = 1'b1;
        sdata      = 1'b0;
        req        = '0;
        note_valid = 1'b0;
        note_ch    = 1'b0;
        note_data  = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // counts are zero out of reset
        read_counts();

        // 40 words per channel, then counts and a sparse window
        for (int i = 0; i < 40; i++) begin
            send_word(1'b0, 1'b0);
            send_word(1'b1, 1'b0);
        end
        read_counts();
        for (int off = 0; off < 40; off += 3) begin
            bus_op(win_addr(0, off), 1'b0);
            bus_op(win_addr(1, off), 1'b0);
        end

        // shifts advance the window
        for (int i = 0; i < 5; i++) begin
            bus_op(reg_addr(0), 1'b1);
            bus_op(win_addr(0, 0), 1'b0);
            if (i < 3) begin
                bus_op(reg_addr(1), 1'b1);
                bus_op(win_addr(1, 0), 1'b0);
            end
        end
        read_counts();
        // shift in the same cycle a sample lands
        send_word(1'b0, 1'b1);
        send_word(1'b1, 1'b1);
        read_counts();

        // unmapped channels, regions and low bytes
        for (int ch = 2; ch < 16; ch++) begin
            bus_op(reg_addr(ch), 1'b0);
            bus_op(reg_addr(ch), 1'b1);
            bus_op(win_addr(ch, 1), 1'b0);
        end
        bus_op(32'h0000_0000, 1'b1);
        bus_op(32'h0000_e000, 1'b1);
        bus_op(32'h0000_3100, 1'b0);
        bus_op(32'h0000_d004, 1'b1);
        bus_op(32'h0000_d180, 1'b1);
        read_counts();

        // wrap both rings past 64 total words
        for (int i = 0; i < 30; i++) begin
            send_word(1'b0, 1'b0);
            send_word(1'b1, 1'b0);
            bus_op(reg_addr(0), 1'b1);
            bus_op(reg_addr(1), 1'b1);
        end
        read_counts();
        for (int off = 0; off < 64; off++) begin
            bus_op(win_addr(0, off), 1'b0);
            bus_op(win_addr(1, off), 1'b0);
        end

        repeat (4) @(posedge clk);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/dai_pkg.sv
dai_rx/i2s_rx_deser.sv
dai_rx/dai_rx_ring.sv
logic/rbus_decode.sv
logic/rbus_readback.sv
dai_rx/dai_rx_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_top
RTL_TOP   ?= dai_rx_top
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "no result in log"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
